// ==== hdl/decoder_macros.svh ====
`ifndef DECODER_MACROS_SVH
`define DECODER_MACROS_SVH

// Opcode field
`define OPC_LSB 0
`define OPC_MSB 7

// Register fields, all REG_W wide
`define REG_W  5
// Stores take their source register from this field
`define RT_LSB 9
`define RA_LSB 14
`define RB_LSB 19
`define RC_LSB 24

// Immediate or displacement, bits 39:19
`define IMM_LSB 19
`define IMM_W   21

// Extension prefix payload, bits 39:9
`define EXI_LSB 9
`define EXI_W   31

// Flow change target fields, each running to the top bit
`define JMP_LSB 9
`define BRA_LSB 14
`define JEQ_LSB 24

`endif

// ==== hdl/decodePkg.sv ====
`default_nettype none

`include "decoder_macros.svh"

package decodePkg;

	// ======================================================================
	// Plain vector types
	// ======================================================================

	// One raw instruction word
	typedef logic [39:0] Instruction;

	// Immediate or data value
	typedef logic [63:0] Value;

	// Branch or jump target
	typedef logic [63:0] Address;

	// Register number
	typedef logic [`REG_W-1:0] RegNum;

	// ======================================================================
	// Encodings
	// ======================================================================

	// Opcodes in the low byte; anything not listed behaves as NOP
	typedef enum logic [7:0]
	{
		R2   = 8'h02,
		ADDI = 8'h04,
		ANDI = 8'h08,
		ORI  = 8'h09,
		JMP  = 8'h20,
		BRA  = 8'h21,
		JEQ  = 8'h26,
		EXI  = 8'h50,
		LDB  = 8'h80,
		LDBU = 8'h81,
		LDW  = 8'h82,
		LDWU = 8'h83,
		LDO  = 8'h86,
		STB  = 8'h90,
		STW  = 8'h91,
		STO  = 8'h93,
		NOP  = 8'hF1
	} Opcode;

	// Memory access size
	typedef enum logic [1:0]
	{
		byt  = 2'd0,
		wyde = 2'd1,
		octa = 2'd2
	} MemSize;

endpackage

`default_nettype wire

// ==== hdl/regSelect.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decoder_macros.svh"

module regSelect
(
	input  decodePkg::Instruction inst,
	output decodePkg::RegNum      Ra,
	output decodePkg::RegNum      Rb,
	output decodePkg::RegNum      Rc,
	output decodePkg::RegNum      Rt,
	output logic                  rfwr
);

	decodePkg::Opcode opcode;

	assign opcode = decodePkg::Opcode'(inst[`OPC_MSB:`OPC_LSB]);

	// Source registers always come straight from their fields
	assign Ra = inst[`RA_LSB +: `REG_W];
	assign Rb = inst[`RB_LSB +: `REG_W];

	// Stores carry their data register in the Rt position
	always_comb
	begin
		case (opcode)
			decodePkg::STB, decodePkg::STW, decodePkg::STO:
				Rc = inst[`RT_LSB +: `REG_W];
			default:
				Rc = inst[`RC_LSB +: `REG_W];
		endcase
	end

	// Target register and register file write
	always_comb
	begin
		case (opcode)
			decodePkg::R2, decodePkg::ADDI, decodePkg::ANDI, decodePkg::ORI,
			decodePkg::LDB, decodePkg::LDBU, decodePkg::LDW, decodePkg::LDWU,
			decodePkg::LDO:
			begin
				Rt = inst[`RT_LSB +: `REG_W];
				rfwr = 1'b1;
			end
			default:
			begin
				Rt = '0;
				rfwr = 1'b0;
			end
		endcase
	end

	// Stores and flow changes never reach the register file
	noWriteOnStoreOrBranch: assert property (@(inst)
		(opcode inside {decodePkg::STB, decodePkg::STW, decodePkg::STO,
			decodePkg::JMP, decodePkg::BRA, decodePkg::JEQ}) |-> (!rfwr && Rt == '0));

endmodule

`default_nettype wire

// ==== hdl/immBuilder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decoder_macros.svh"

module immBuilder
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  instValid,
	input  decodePkg::Instruction inst,
	output decodePkg::Value       imm
);

	decodePkg::Opcode opcode;
	logic [`IMM_W-1:0] immField;
	logic [`EXI_W-1:0] exiPayload;
	logic exiValid;
	logic takesImm;

	assign opcode = decodePkg::Opcode'(inst[`OPC_MSB:`OPC_LSB]);
	assign immField = inst[`IMM_LSB +: `IMM_W];

	// ======================================================================
	// Extension prefix
	// ======================================================================

	// Flag is set by EXI and dropped by the next accepted instruction
	always_ff @(posedge clk)
	begin
		if (reset)
			exiValid <= 1'b0;
		else if (instValid)
			exiValid <= (opcode == decodePkg::EXI);
	end

	// A later EXI simply overwrites the stored payload
	always_ff @(posedge clk)
	begin
		if (instValid && opcode == decodePkg::EXI)
			exiPayload <= inst[`EXI_LSB +: `EXI_W];
	end

	// ======================================================================
	// Immediate construction
	// ======================================================================

	assign takesImm = opcode inside {decodePkg::ADDI, decodePkg::ANDI, decodePkg::ORI,
		decodePkg::LDB, decodePkg::LDBU, decodePkg::LDW, decodePkg::LDWU, decodePkg::LDO,
		decodePkg::STB, decodePkg::STW, decodePkg::STO};

	always_comb
	begin
		case (opcode)
			decodePkg::ANDI:
				imm = {{($bits(decodePkg::Value) - `IMM_W){1'b1}}, immField};
			decodePkg::ORI:
				imm = {{($bits(decodePkg::Value) - `IMM_W){1'b0}}, immField};
			decodePkg::ADDI, decodePkg::LDB, decodePkg::LDBU, decodePkg::LDW,
			decodePkg::LDWU, decodePkg::LDO, decodePkg::STB, decodePkg::STW,
			decodePkg::STO:
				imm = {{($bits(decodePkg::Value) - `IMM_W){immField[`IMM_W-1]}}, immField};
			default:
				imm = '0;
		endcase
		// Prefix replaces everything above the low immediate bits
		if (exiValid && takesImm)
			imm = {{($bits(decodePkg::Value) - `EXI_W - `IMM_W){exiPayload[`EXI_W-1]}},
				exiPayload, immField};
	end

	prefixConsumed: assert property (@(posedge clk) disable iff (reset)
		(instValid && opcode != decodePkg::EXI) |=> !exiValid);

endmodule

`default_nettype wire

// ==== hdl/memClassDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decoder_macros.svh"

module memClassDecode
(
	input  decodePkg::Instruction inst,
	output logic                  isLoad,
	output logic                  isStore,
	output logic                  loadZeroExt,
	output decodePkg::MemSize     memSize
);

	decodePkg::Opcode opcode;

	assign opcode = decodePkg::Opcode'(inst[`OPC_MSB:`OPC_LSB]);

	assign isLoad = opcode inside {decodePkg::LDB, decodePkg::LDBU, decodePkg::LDW,
		decodePkg::LDWU, decodePkg::LDO};
	assign isStore = opcode inside {decodePkg::STB, decodePkg::STW, decodePkg::STO};

	// Unsigned loads zero the upper bits of the loaded data
	assign loadZeroExt = opcode inside {decodePkg::LDBU, decodePkg::LDWU};

	always_comb
	begin
		case (opcode)
			decodePkg::LDB, decodePkg::LDBU, decodePkg::STB:
				memSize = decodePkg::byt;
			decodePkg::LDW, decodePkg::LDWU, decodePkg::STW:
				memSize = decodePkg::wyde;
			default:
				memSize = decodePkg::octa;
		endcase
	end

	loadStoreExclusive: assert property (@(inst) !(isLoad && isStore));

endmodule

`default_nettype wire

// ==== hdl/branchDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decoder_macros.svh"

module branchDecode
(
	input  decodePkg::Instruction inst,
	output logic                  isFlowChange,
	output logic                  isCondBranch,
	output decodePkg::Address     jmpTarget
);

	decodePkg::Opcode opcode;
	logic [39-`JMP_LSB:0] jmpField;
	logic [39-`BRA_LSB:0] braField;
	logic [39-`JEQ_LSB:0] jeqField;

	assign opcode = decodePkg::Opcode'(inst[`OPC_MSB:`OPC_LSB]);
	assign jmpField = inst[39:`JMP_LSB];
	assign braField = inst[39:`BRA_LSB];
	assign jeqField = inst[39:`JEQ_LSB];

	assign isFlowChange = opcode inside {decodePkg::JMP, decodePkg::BRA, decodePkg::JEQ};
	assign isCondBranch = (opcode == decodePkg::JEQ);

	// Targets are halfword aligned, so the low bit is always zero
	always_comb
	begin
		case (opcode)
			decodePkg::BRA:
				jmpTarget = {{(63 - $bits(braField)){braField[$high(braField)]}}, braField, 1'b0};
			decodePkg::JEQ:
				jmpTarget = {{(63 - $bits(jeqField)){jeqField[$high(jeqField)]}}, jeqField, 1'b0};
			default:
				jmpTarget = {{(63 - $bits(jmpField)){jmpField[$high(jmpField)]}}, jmpField, 1'b0};
		endcase
	end

	condImpliesFlow: assert property (@(inst) isCondBranch |-> isFlowChange);

endmodule

`default_nettype wire

// ==== hdl/instDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decoder_macros.svh"

module instDecoder
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  instValid,
	input  decodePkg::Instruction inst,
	output logic                  decValid,
	output decodePkg::RegNum      Ra,
	output decodePkg::RegNum      Rb,
	output decodePkg::RegNum      Rc,
	output decodePkg::RegNum      Rt,
	output logic                  rfwr,
	output decodePkg::Value       imm,
	output logic                  isLoad,
	output logic                  isStore,
	output logic                  loadZeroExt,
	output decodePkg::MemSize     memSize,
	output logic                  isFlowChange,
	output logic                  isCondBranch,
	output decodePkg::Address     jmpTarget
);

	decodePkg::RegNum raNext, rbNext, rcNext, rtNext;
	decodePkg::Value immNext;
	decodePkg::MemSize memSizeNext;
	decodePkg::Address targetNext;
	logic rfwrNext, loadNext, storeNext, zeroExtNext, flowNext, condNext;
	logic accept;

	// ======================================================================
	// Decoders, all looking at the same instruction
	// ======================================================================

	regSelect regSelect_i
	(
		.inst(inst), .Ra(raNext), .Rb(rbNext), .Rc(rcNext), .Rt(rtNext), .rfwr(rfwrNext)
	);

	immBuilder immBuilder_i
	(
		.clk(clk), .reset(reset), .instValid(instValid), .inst(inst), .imm(immNext)
	);

	memClassDecode memClassDecode_i
	(
		.inst(inst), .isLoad(loadNext), .isStore(storeNext), .loadZeroExt(zeroExtNext),
		.memSize(memSizeNext)
	);

	branchDecode branchDecode_i
	(
		.inst(inst), .isFlowChange(flowNext), .isCondBranch(condNext),
		.jmpTarget(targetNext)
	);

	// ======================================================================
	// Result register
	// ======================================================================

	// A prefix alone never yields a result
	assign accept = instValid && (inst[`OPC_MSB:`OPC_LSB] != decodePkg::EXI);

	always_ff @(posedge clk)
	begin
		if (reset)
			decValid <= 1'b0;
		else
			decValid <= accept;
	end

	// Results hold between pulses
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			Ra <= raNext;
			Rb <= rbNext;
			Rc <= rcNext;
			Rt <= rtNext;
			rfwr <= rfwrNext;
			imm <= immNext;
			isLoad <= loadNext;
			isStore <= storeNext;
			loadZeroExt <= zeroExtNext;
			memSize <= memSizeNext;
			isFlowChange <= flowNext;
			isCondBranch <= condNext;
			jmpTarget <= targetNext;
		end
	end

endmodule

`default_nettype wire

// ==== bench/instDecoderTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "decoder_macros.svh"

module instDecoderTb;

	logic clk;
	logic reset;
	logic instValid;
	decodePkg::Instruction inst;
	logic decValid;
	decodePkg::RegNum Ra, Rb, Rc, Rt;
	logic rfwr;
	decodePkg::Value imm;
	logic isLoad, isStore, loadZeroExt;
	decodePkg::MemSize memSize;
	logic isFlowChange, isCondBranch;
	decodePkg::Address jmpTarget;

	instDecoder instDecoder_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic stopRun();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic checkRegNum(input string name, input decodePkg::RegNum got,
		input decodePkg::RegNum exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkValue(input string name, input decodePkg::Value got,
		input decodePkg::Value exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkAddress(input string name, input decodePkg::Address got,
		input decodePkg::Address exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkMemSize(input string name, input decodePkg::MemSize got,
		input decodePkg::MemSize exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			stopRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			stopRun();
		end
	endtask

	// ======================================================================
	// Stimulus helpers
	// ======================================================================

	// Rb and Rc live in the low bits of the upper field
	function automatic decodePkg::Instruction encode(input decodePkg::Opcode op,
		input decodePkg::RegNum rt, input decodePkg::RegNum ra, input logic [`IMM_W-1:0] upper);
		decodePkg::Instruction word;
		word = '0;
		word[`OPC_MSB:`OPC_LSB] = op;
		word[`RT_LSB +: `REG_W] = rt;
		word[`RA_LSB +: `REG_W] = ra;
		word[`IMM_LSB +: `IMM_W] = upper;
		return word;
	endfunction

	// One strobe followed by a wait for the result pulse
	task automatic issue(input decodePkg::Instruction word);
		int waited;
		@(negedge clk);
		inst = word;
		instValid = 1'b1;
		@(negedge clk);
		instValid = 1'b0;
		waited = 0;
		while (decValid !== 1'b1)
		begin
			if (waited == 10)
			begin
				$display("No decode result within 10 cycles of the strobe");
				stopRun();
			end
			@(negedge clk);
			waited++;
		end
	endtask

	// EXI must stay silent on decValid
	task automatic sendPrefix(input logic [`EXI_W-1:0] payload);
		decodePkg::Instruction word;
		int cycle;
		word = '0;
		word[`OPC_MSB:`OPC_LSB] = decodePkg::EXI;
		word[`EXI_LSB +: `EXI_W] = payload;
		@(negedge clk);
		inst = word;
		instValid = 1'b1;
		@(negedge clk);
		instValid = 1'b0;
		for (cycle = 0; cycle < 3; cycle++)
		begin
			checkFlag("decValid", decValid, 1'b0);
			@(negedge clk);
		end
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	task automatic registerWrites();
		decodePkg::RegNum rt, ra;
		logic [`IMM_W-1:0] upper;
		decodePkg::Instruction word;
		rt = $urandom;
		ra = $urandom;
		upper = $urandom;
		word = encode(decodePkg::R2, rt, ra, upper);
		issue(word);
		checkRegNum("Ra", Ra, ra);
		checkRegNum("Rb", Rb, word[`RB_LSB +: `REG_W]);
		checkRegNum("Rc", Rc, word[`RC_LSB +: `REG_W]);
		checkRegNum("Rt", Rt, rt);
		checkFlag("rfwr", rfwr, 1'b1);
		word = encode(decodePkg::ADDI, ~rt, ~ra, ~upper);
		issue(word);
		checkRegNum("Ra", Ra, ~ra);
		checkRegNum("Rb", Rb, word[`RB_LSB +: `REG_W]);
		checkRegNum("Rt", Rt, ~rt);
		checkFlag("rfwr", rfwr, 1'b1);
		// Store data register comes out on Rc
		issue(encode(decodePkg::STO, rt, ra, upper));
		checkRegNum("Rc", Rc, rt);
		checkRegNum("Rt", Rt, 5'd0);
		checkFlag("rfwr", rfwr, 1'b0);
	endtask

	task automatic immPadding();
		logic [`IMM_W-1:0] field;
		field = $urandom;
		field[`IMM_W-1] = 1'b1;
		issue(encode(decodePkg::ADDI, 5'd1, 5'd2, field));
		checkValue("imm", imm, {{(64-`IMM_W){1'b1}}, field});
		field[`IMM_W-1] = 1'b0;
		issue(encode(decodePkg::ANDI, 5'd1, 5'd2, field));
		checkValue("imm", imm, {{(64-`IMM_W){1'b1}}, field});
		field[`IMM_W-1] = 1'b1;
		issue(encode(decodePkg::ORI, 5'd1, 5'd2, field));
		checkValue("imm", imm, {{(64-`IMM_W){1'b0}}, field});
		issue(encode(decodePkg::R2, 5'd1, 5'd2, field));
		checkValue("imm", imm, 64'd0);
	endtask

	task automatic prefixWidening();
		logic [`EXI_W-1:0] payload;
		logic [`IMM_W-1:0] field;
		payload = $urandom;
		payload[`EXI_W-1] = 1'b1;
		field = $urandom;
		sendPrefix(payload);
		issue(encode(decodePkg::ADDI, 5'd3, 5'd4, field));
		checkValue("imm", imm, {{(64-`EXI_W-`IMM_W){1'b1}}, payload, field});
		// The first ADDI used up the prefix
		issue(encode(decodePkg::ADDI, 5'd3, 5'd4, field));
		checkValue("imm", imm, {{(64-`IMM_W){field[`IMM_W-1]}}, field});
	endtask

	task automatic checkMemOp(input decodePkg::Opcode op, input logic load, input logic store,
		input logic zeroExt, input decodePkg::MemSize size);
		issue(encode(op, $urandom, $urandom, $urandom));
		checkFlag("isLoad", isLoad, load);
		checkFlag("isStore", isStore, store);
		checkFlag("loadZeroExt", loadZeroExt, zeroExt);
		checkMemSize("memSize", memSize, size);
		checkFlag("isFlowChange", isFlowChange, 1'b0);
	endtask

	task automatic memoryClasses();
		checkMemOp(decodePkg::LDB, 1'b1, 1'b0, 1'b0, decodePkg::byt);
		checkMemOp(decodePkg::LDBU, 1'b1, 1'b0, 1'b1, decodePkg::byt);
		checkMemOp(decodePkg::LDW, 1'b1, 1'b0, 1'b0, decodePkg::wyde);
		checkMemOp(decodePkg::LDWU, 1'b1, 1'b0, 1'b1, decodePkg::wyde);
		checkMemOp(decodePkg::LDO, 1'b1, 1'b0, 1'b0, decodePkg::octa);
		checkMemOp(decodePkg::STB, 1'b0, 1'b1, 1'b0, decodePkg::byt);
		checkMemOp(decodePkg::STW, 1'b0, 1'b1, 1'b0, decodePkg::wyde);
		checkMemOp(decodePkg::STO, 1'b0, 1'b1, 1'b0, decodePkg::octa);
	endtask

	task automatic checkBranch(input decodePkg::Opcode op, input int lsb, input logic negative,
		input logic cond);
		decodePkg::Instruction word;
		decodePkg::Address expected;
		word = {$urandom, $urandom};
		word[39] = negative;
		word[`OPC_MSB:`OPC_LSB] = op;
		// Sign extend bits 39 down to lsb and shift in a zero low bit
		expected = ($signed({word, 24'd0}) >>> (24 + lsb)) << 1;
		issue(word);
		checkAddress("jmpTarget", jmpTarget, expected);
		checkFlag("isFlowChange", isFlowChange, 1'b1);
		checkFlag("isCondBranch", isCondBranch, cond);
	endtask

	task automatic branchTargets();
		checkBranch(decodePkg::JMP, `JMP_LSB, 1'b1, 1'b0);
		checkBranch(decodePkg::JMP, `JMP_LSB, 1'b0, 1'b0);
		checkBranch(decodePkg::BRA, `BRA_LSB, 1'b1, 1'b0);
		checkBranch(decodePkg::BRA, `BRA_LSB, 1'b0, 1'b0);
		checkBranch(decodePkg::JEQ, `JEQ_LSB, 1'b1, 1'b1);
		checkBranch(decodePkg::JEQ, `JEQ_LSB, 1'b0, 1'b1);
	endtask

	task automatic backToBack();
		decodePkg::Instruction words [3];
		logic [`IMM_W-1:0] fields [3];
		int i;
		for (i = 0; i < 3; i++)
		begin
			fields[i] = $urandom;
			words[i] = encode(decodePkg::ORI, 5'(i + 1), 5'd0, fields[i]);
		end
		@(negedge clk);
		inst = words[0];
		instValid = 1'b1;
		// Each pulse belongs to the strobe one cycle earlier
		for (i = 1; i <= 3; i++)
		begin
			@(negedge clk);
			if (i < 3)
				inst = words[i];
			else
				instValid = 1'b0;
			checkFlag("decValid", decValid, 1'b1);
			checkRegNum("Rt", Rt, 5'(i));
			checkValue("imm", imm, {{(64-`IMM_W){1'b0}}, fields[i-1]});
		end
		@(negedge clk);
		checkFlag("decValid", decValid, 1'b0);
	endtask

	task automatic resetClearsPrefix();
		logic [`IMM_W-1:0] field;
		// A strobe that meets reset yields no pulse
		@(negedge clk);
		inst = encode(decodePkg::ORI, 5'd5, 5'd6, 21'd0);
		instValid = 1'b1;
		reset = 1'b1;
		@(negedge clk);
		instValid = 1'b0;
		reset = 1'b0;
		checkFlag("decValid", decValid, 1'b0);
		sendPrefix({1'b1, 30'($urandom)});
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		field = $urandom;
		issue(encode(decodePkg::ORI, 5'd7, 5'd8, field));
		checkValue("imm", imm, {{(64-`IMM_W){1'b0}}, field});
	endtask

	initial
	begin
		void'($urandom(32'ha948));
		reset = 1'b1;
		instValid = 1'b0;
		inst = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		registerWrites();
		immPadding();
		prefixWidening();
		memoryClasses();
		branchTargets();
		backToBack();
		resetClearsPrefix();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/decodePkg.sv
hdl/regSelect.sv
hdl/immBuilder.sv
hdl/memClassDecode.sv
hdl/branchDecode.sv
hdl/instDecoder.sv
bench/instDecoderTb.sv

// ==== Bender.yml ====
package:
  name: instDecoder

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/decodePkg.sv
      - hdl/regSelect.sv
      - hdl/immBuilder.sv
      - hdl/memClassDecode.sv
      - hdl/branchDecode.sv
      - hdl/instDecoder.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/instDecoderTb.sv
